//--- hw/rv_pkg.sv
package rv_pkg;

    localparam int xlen      = 32;                // data word width
    localparam int mem_words = 64;                // words in each memory
    localparam int addr_bits = 8;                 // byte address bits of one memory
    localparam int word_bits = $clog2(mem_words); // word index bits
    localparam int reg_bits  = 5;                 // rs1, rs2 and rd field width

    // base opcodes, low seven bits of every instruction
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_system = 7'b1110011; // ecall halts

    typedef enum logic [2:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt, alu_pass_b
    } alu_op_t;

    // instruction formats, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [reg_bits-1:0] rs2;
        logic [reg_bits-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_bits-1:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [reg_bits-1:0] rs1;
        logic [2:0] funct3;
        logic [reg_bits-1:0] rd;
        logic [6:0] opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [reg_bits-1:0] rs2;
        logic [reg_bits-1:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic imm_12;
        logic [5:0] imm_10_5;
        logic [reg_bits-1:0] rs2;
        logic [reg_bits-1:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic imm_20;
        logic [9:0] imm_10_1;
        logic imm_11;
        logic [7:0] imm_19_12;
        logic [reg_bits-1:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one fetched word, viewed through whichever format the opcode needs
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    typedef struct packed {
        logic [addr_bits:0] addr; // top bit picks data memory
        logic [xlen-1:0]    din;
        logic [3:0]         we;   // byte enables
    } host_req_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     pc;
        logic [xlen-1:0]     rs1_data;
        logic [xlen-1:0]     rs2_data;
        logic [xlen-1:0]     imm;
        logic [reg_bits-1:0] rs1;
        logic [reg_bits-1:0] rs2;
        logic [reg_bits-1:0] rd;
        alu_op_t             alu_op;
        logic                use_imm;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                branch_ne;
        logic                is_jal;
        logic                reg_we;  // never set for x0
        logic                halt;
    } id_ex_t;

    typedef struct packed {
        logic                valid;
        logic [xlen-1:0]     result;
        logic [xlen-1:0]     store_data;
        logic [reg_bits-1:0] rd;
        logic                is_load;
        logic                is_store;
        logic                reg_we;
        logic                halt;
    } ex_mem_t;

    typedef struct packed {
        logic [reg_bits-1:0] rd;
        logic [xlen-1:0]     data;
        logic                we;
    } wb_t;

    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] target;
    } redirect_t;

endpackage

//--- hw/instruction_fetch.sv
`timescale 1ns/100ps

module instruction_fetch import rv_pkg::*; (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            run,
    input  logic            stall,      // load-use or halt hold from decode
    input  redirect_t       redirect,
    input  host_req_t       host,       // byte enables already masked by the top
    output logic [xlen-1:0] host_rdata,
    output if_id_t          if_id
);

    logic [xlen-1:0]      mem [mem_words]; // instruction ram
    logic [xlen-1:0]      pc;
    logic [word_bits-1:0] host_addr;
    logic [word_bits-1:0] pc_addr;

    assign host_addr = host.addr[word_bits+1:2];
    assign pc_addr   = pc[word_bits+1:2];      // word index, low two bits dropped

    // port b, host side with byte lanes
    always_ff @(posedge clk_in) begin
        for (int lane = 0; lane < 4; lane++) begin
            if (host.we[lane])
                mem[host_addr][lane*8 +: 8] <= host.din[lane*8 +: 8];
        end
        host_rdata <= mem[host_addr]; // readback one cycle later
    end

    // port a read doubles as the if/id register
    always_ff @(posedge clk_in) begin
        if (reset) begin
            pc          <= '0;
            if_id.valid <= 1'b0;
        end else if (run) begin
            if (redirect.valid) begin
                pc          <= redirect.target;
                if_id.valid <= 1'b0;      // squash the wrong-path fetch
            end else if (!stall) begin
                pc          <= pc + 4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= mem[pc_addr];
            end
            // stalled, pc and if/id keep their values
        end
    end

endmodule

//--- hw/instruction_decode.sv
`timescale 1ns/100ps

module instruction_decode import rv_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  logic      run,
    input  if_id_t    if_id,
    input  wb_t       wb,         // write port from mem/wb
    input  redirect_t redirect,
    output logic      stall,
    output id_ex_t    id_ex
);

    logic [xlen-1:0]     regs [32];  // x0 slot never written
    instr_u              word;
    logic [6:0]          opcode;
    logic [reg_bits-1:0] rs1;
    logic [reg_bits-1:0] rs2;
    logic [reg_bits-1:0] rd;
    logic                uses_rs1;
    logic                uses_rs2;
    logic                writes_rd;
    logic                load_use;
    logic                hold;       // set once a live ecall passes, only bubbles after
    id_ex_t              dec;        // next id/ex entry

    // register read with write-through from the same cycle's wb
    function automatic logic [xlen-1:0] rf_read(logic [reg_bits-1:0] idx);
        if (idx == '0)
            return '0;
        if (wb.we && wb.rd == idx)
            return wb.data;
        return regs[idx];
    endfunction

    function automatic alu_op_t funct_op(logic [2:0] funct3, logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add; // funct7 bit 5 picks sub
            3'b010:  return alu_slt;
            3'b100:  return alu_xor;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    assign word   = if_id.instr;
    assign opcode = word.r_fmt.opcode;
    assign rs1    = word.r_fmt.rs1;    // same position in every format that has it
    assign rs2    = word.r_fmt.rs2;
    assign rd     = word.r_fmt.rd;

    always_comb begin
        dec          = '0;
        dec.valid    = if_id.valid;
        dec.pc       = if_id.pc;
        dec.rs1      = rs1;
        dec.rs2      = rs2;
        dec.rd       = rd;
        dec.rs1_data = rf_read(rs1);
        dec.rs2_data = rf_read(rs2);
        dec.alu_op   = alu_add;
        uses_rs1     = 1'b0;
        uses_rs2     = 1'b0;
        writes_rd    = 1'b0;
        case (opcode)
            op_reg: begin
                uses_rs1   = 1'b1;
                uses_rs2   = 1'b1;
                writes_rd  = 1'b1;
                dec.alu_op = funct_op(word.r_fmt.funct3, word.r_fmt.funct7[5]);
            end
            op_imm: begin
                uses_rs1    = 1'b1;
                writes_rd   = 1'b1;
                dec.use_imm = 1'b1;
                dec.imm     = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
                dec.alu_op  = funct_op(word.i_fmt.funct3, 1'b0); // no subi
            end
            op_lui: begin
                writes_rd   = 1'b1;
                dec.use_imm = 1'b1;
                dec.alu_op  = alu_pass_b;
                // upper 20 bits sit where the j fields are, in order
                dec.imm = {word.j_fmt.imm_20, word.j_fmt.imm_10_1, word.j_fmt.imm_11,
                           word.j_fmt.imm_19_12, 12'b0};
            end
            op_load: begin
                uses_rs1    = 1'b1;
                writes_rd   = 1'b1;
                dec.use_imm = 1'b1;
                dec.is_load = 1'b1;
                dec.imm     = {{20{word.i_fmt.imm[11]}}, word.i_fmt.imm};
            end
            op_store: begin
                uses_rs1     = 1'b1;
                uses_rs2     = 1'b1;
                dec.use_imm  = 1'b1;
                dec.is_store = 1'b1;
                dec.imm = {{20{word.s_fmt.imm_hi[6]}}, word.s_fmt.imm_hi, word.s_fmt.imm_lo};
            end
            op_branch: begin
                uses_rs1      = 1'b1;
                uses_rs2      = 1'b1;
                dec.is_branch = 1'b1;
                dec.branch_ne = word.b_fmt.funct3[0]; // bne is 001
                dec.imm = {{19{word.b_fmt.imm_12}}, word.b_fmt.imm_12, word.b_fmt.imm_11,
                           word.b_fmt.imm_10_5, word.b_fmt.imm_4_1, 1'b0};
            end
            op_jal: begin
                writes_rd  = 1'b1;
                dec.is_jal = 1'b1;
                dec.imm = {{11{word.j_fmt.imm_20}}, word.j_fmt.imm_20, word.j_fmt.imm_19_12,
                           word.j_fmt.imm_11, word.j_fmt.imm_10_1, 1'b0};
            end
            op_system: dec.halt = 1'b1;
            default: ;  // unsupported opcodes pass as nops
        endcase
        dec.reg_we = writes_rd && rd != '0;  // x0 writes dropped here
    end

    // load in ex feeding the instruction in id
    assign load_use = if_id.valid && id_ex.valid && id_ex.is_load && id_ex.reg_we &&
                      ((uses_rs1 && rs1 == id_ex.rd) || (uses_rs2 && rs2 == id_ex.rd));
    assign stall = load_use || hold;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            hold  <= 1'b0;
            id_ex <= '0;
        end else if (run) begin
            if (dec.valid && dec.halt && !redirect.valid)
                hold <= 1'b1;
            if (redirect.valid || stall || !if_id.valid)
                id_ex <= '0;   // bubble
            else
                id_ex <= dec;
        end
    end

    always_ff @(posedge clk_in) begin
        if (run && wb.we && wb.rd != '0)
            regs[wb.rd] <= wb.data;
    end

endmodule

//--- hw/execute.sv
`timescale 1ns/100ps

module execute import rv_pkg::*; (
    input  logic      clk_in,
    input  logic      reset,
    input  logic      run,
    input  id_ex_t    id_ex,
    output ex_mem_t   ex_mem,
    input  wb_t       wb,
    output redirect_t redirect
);

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;    // forwarded rs2, also the store data
    logic [xlen-1:0] alu_b;
    logic [xlen-1:0] result;
    logic            taken;

    // newest producer wins, loads in ex/mem are not ready yet
    function automatic logic [xlen-1:0] forward(logic [reg_bits-1:0] idx,
                                                 logic [xlen-1:0] rf_data);
        if (ex_mem.valid && ex_mem.reg_we && !ex_mem.is_load && ex_mem.rd == idx)
            return ex_mem.result;
        if (wb.we && wb.rd == idx)
            return wb.data;
        return rf_data;
    endfunction

    always_comb begin
        op_a  = forward(id_ex.rs1, id_ex.rs1_data);
        op_b  = forward(id_ex.rs2, id_ex.rs2_data);
        alu_b = id_ex.use_imm ? id_ex.imm : op_b;
    end

    always_comb begin
        case (id_ex.alu_op)
            alu_add:    result = op_a + alu_b;
            alu_sub:    result = op_a - alu_b;
            alu_and:    result = op_a & alu_b;
            alu_or:     result = op_a | alu_b;
            alu_xor:    result = op_a ^ alu_b;
            alu_slt:    result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(alu_b)};
            alu_pass_b: result = alu_b;           // lui
            default:    result = op_a + alu_b;
        endcase
        if (id_ex.is_jal)
            result = id_ex.pc + 4;                // link value
    end

    assign taken = id_ex.is_branch && ((op_a == op_b) != id_ex.branch_ne);

    // branch and jal share the pc-relative target
    assign redirect.valid  = id_ex.valid && (taken || id_ex.is_jal);
    assign redirect.target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clk_in) begin
        if (reset) begin
            ex_mem <= '0;
        end else if (run) begin
            ex_mem.valid      <= id_ex.valid;
            ex_mem.result     <= result;
            ex_mem.store_data <= op_b;
            ex_mem.rd         <= id_ex.rd;
            ex_mem.is_load    <= id_ex.valid && id_ex.is_load;
            ex_mem.is_store   <= id_ex.valid && id_ex.is_store;
            ex_mem.reg_we     <= id_ex.valid && id_ex.reg_we;
            ex_mem.halt       <= id_ex.valid && id_ex.halt;
        end
    end

endmodule

//--- hw/memory_access.sv
`timescale 1ns/100ps

module memory_access import rv_pkg::*; (
    input  logic            clk_in,
    input  logic            reset,
    input  logic            run,
    input  ex_mem_t         ex_mem,
    input  host_req_t       host,        // byte enables already masked by the top
    output logic [xlen-1:0] host_rdata,
    output wb_t             wb,
    output logic            halt
);

    logic [xlen-1:0]      mem [mem_words]; // data ram
    logic [word_bits-1:0] core_addr;
    logic [word_bits-1:0] host_addr;
    logic [xlen-1:0]      load_data;        // port a output register
    wb_t                  wb_q;             // result path of mem/wb
    logic                 sel_load;

    assign core_addr = ex_mem.result[word_bits+1:2];  // word stores only
    assign host_addr = host.addr[word_bits+1:2];

    // both ports in one process, core on a, host on b
    always_ff @(posedge clk_in) begin
        if (run) begin
            if (ex_mem.is_store)
                mem[core_addr] <= ex_mem.store_data;
            load_data <= mem[core_addr];
        end
        for (int lane = 0; lane < 4; lane++) begin
            if (host.we[lane])
                mem[host_addr][lane*8 +: 8] <= host.din[lane*8 +: 8];
        end
        host_rdata <= mem[host_addr];
    end

    always_ff @(posedge clk_in) begin
        if (reset) begin
            wb_q.we  <= 1'b0;
            sel_load <= 1'b0;
            halt     <= 1'b0;
        end else if (run) begin
            wb_q     <= '{rd: ex_mem.rd, data: ex_mem.result, we: ex_mem.reg_we};
            sel_load <= ex_mem.is_load;
            halt     <= ex_mem.halt;   // ecall reached the end
        end
    end

    // write-back select
    assign wb = '{rd: wb_q.rd, data: sel_load ? load_data : wb_q.data, we: wb_q.we};

endmodule

//--- hw/pipelined_processor.sv
`timescale 1ns/100ps

module pipelined_processor import rv_pkg::*; (
    input  logic            clk_in,
    input  logic            reset,
    input  host_req_t       host,
    output logic [xlen-1:0] bram_dout,
    output logic            run        // high until the program halts
);

    host_req_t       imem_host;
    host_req_t       dmem_host;
    logic [xlen-1:0] imem_rdata;
    logic [xlen-1:0] dmem_rdata;
    logic            dmem_sel;    // address bit of the previous cycle
    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    wb_t             wb;
    redirect_t       redirect;
    logic            stall;
    logic            halt;

    // top address bit steers the byte enables
    always_comb begin
        imem_host    = host;
        dmem_host    = host;
        imem_host.we = host.we & {4{~host.addr[addr_bits]}};
        dmem_host.we = host.we & {4{host.addr[addr_bits]}};
    end

    always_ff @(posedge clk_in) begin
        dmem_sel <= host.addr[addr_bits]; // lines up with the ram read latency
    end

    assign bram_dout = dmem_sel ? dmem_rdata : imem_rdata;

    // run acts as clock enable for every stage
    always_ff @(posedge clk_in) begin
        if (reset)
            run <= 1'b1;
        else if (halt)
            run <= 1'b0;
    end

    instruction_fetch if_stage (
        .clk_in(clk_in), .reset(reset), .run(run), .stall(stall),
        .redirect(redirect), .host(imem_host), .host_rdata(imem_rdata), .if_id(if_id)
    );

    instruction_decode id_stage (
        .clk_in(clk_in), .reset(reset), .run(run), .if_id(if_id), .wb(wb),
        .redirect(redirect), .stall(stall), .id_ex(id_ex)
    );

    execute ex_stage (
        .clk_in(clk_in), .reset(reset), .run(run), .id_ex(id_ex),
        .ex_mem(ex_mem), .wb(wb), .redirect(redirect)
    );

    memory_access mem_stage (
        .clk_in(clk_in), .reset(reset), .run(run), .ex_mem(ex_mem),
        .host(dmem_host), .host_rdata(dmem_rdata), .wb(wb), .halt(halt)
    );

endmodule

//--- test/processor_props.sv
`timescale 1ns/100ps

module processor_props import rv_pkg::*; (
    input logic            clk_in,
    input logic            reset,
    input host_req_t       host,
    input logic [xlen-1:0] bram_dout,
    input logic            run
);

    int fail_count = 0;  // failed property count, read by processor_tb

    // run is set by reset
    run_after_reset: assert property (@(posedge clk_in) reset |=> run)
        else begin
            $error("run is low on the cycle after reset");
            fail_count++;
        end

    // a halted core stays halted until the next reset
    run_stays_low: assert property (@(posedge clk_in) (!run && !reset) |=> !run)
        else begin
            $error("run rose again without a reset");
            fail_count++;
        end

    // every ram word is written while reset is high, so a read after that is never x
    readback_known: assert property (@(posedge clk_in)
        (!reset && host.we == 4'h0) |=> !$isunknown(bram_dout))
        else begin
            $error("bram_dout has unknown bits one cycle after a host read");
            fail_count++;
        end

endmodule

//--- test/processor_tb.sv
`timescale 1ns/100ps

module processor_tb import rv_pkg::*; ();

    localparam int run_limit   = 1000;  // cycles allowed for the program to halt
    localparam int rand_writes = 48;

    logic            clk_in;
    logic            reset;
    host_req_t       host;
    logic [xlen-1:0] bram_dout;
    logic            run;

    logic [xlen-1:0] imem_model [mem_words];  // expected instruction ram
    logic [xlen-1:0] dmem_model [mem_words];  // expected data ram
    logic [xlen-1:0] prog [$];                // test program with word 0 first
    integer          seed;

    pipelined_processor UUT (
        .clk_in(clk_in), .reset(reset), .host(host), .bram_dout(bram_dout), .run(run)
    );

    bind pipelined_processor processor_props props (
        .clk_in(clk_in), .reset(reset), .host(host), .bram_dout(bram_dout), .run(run)
    );

    initial begin
        clk_in = 1'b0;
        forever #2 clk_in = ~clk_in;  // 4 ns period
    end

    task automatic stop_with_fail(input string why);
        $display("%s", why);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on the first error");
    endtask

    // stop on the first failed property
    always @(negedge clk_in) begin
        if (UUT.props.fail_count != 0)
            stop_with_fail("a property check on the top-level ports failed");
    end

    // host byte-lane write semantics
    function automatic logic [xlen-1:0] merge_bytes(logic [xlen-1:0] old,
                                                    logic [xlen-1:0] din, logic [3:0] we);
        logic [xlen-1:0] res;
        res = old;
        for (int lane = 0; lane < 4; lane++) begin
            if (we[lane])
                res[lane*8 +: 8] = din[lane*8 +: 8];
        end
        return res;
    endfunction

    // rv32i encodings
    function automatic logic [31:0] r_word(logic [6:0] f7, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    function automatic logic [31:0] i_word(logic [6:0] op, logic [2:0] f3, logic [4:0] rd,
                                           logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] sw_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [31:0] branch_word(logic [2:0] f3, logic [4:0] rs1,
                                                logic [4:0] rs2, logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], op_branch};
    endfunction

    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, op_jal};
    endfunction

    // lui + addi pair with the upper part rounded for the sign-extended low part
    task automatic load_constant(input logic [4:0] rd, input logic [xlen-1:0] value);
        logic [xlen-1:0] upper;
        upper = (value + 32'h800) >> 12;
        prog.push_back({upper[19:0], rd, op_lui});
        prog.push_back(i_word(op_imm, 3'b000, rd, rd, value[11:0]));
    endtask

    task automatic host_write(input logic sel, input logic [word_bits-1:0] idx,
                              input logic [xlen-1:0] data, input logic [3:0] we);
        host.addr = {sel, idx, 2'b00};
        host.din  = data;
        host.we   = we;
        @(negedge clk_in);
        host.we = 4'h0;
        if (sel)
            dmem_model[idx] = merge_bytes(dmem_model[idx], data, we);
        else
            imem_model[idx] = merge_bytes(imem_model[idx], data, we);
    endtask

    // word comes back one cycle after the address
    task automatic host_check(input logic sel, input logic [word_bits-1:0] idx);
        logic [xlen-1:0] expected;
        string           which;
        expected = sel ? dmem_model[idx] : imem_model[idx];
        if (sel)
            which = "data";
        else
            which = "instr";
        host.addr = {sel, idx, 2'b00};
        host.we   = 4'h0;
        @(negedge clk_in);
        assert (bram_dout === expected) else
            stop_with_fail($sformatf("** Error at %0t ns: %s word %0d read %h, expected %h",
                                     $time, which, idx, bram_dout, expected));
    endtask

    initial begin
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] rnd;
        logic [xlen-1:0] res [6];
        int              jal_pc;
        int              cycles;
        seed  = 32'h7886_2b9c;
        reset = 1'b1;
        host  = '0;
        repeat (3) @(negedge clk_in);  // reset stays high through loading

        // addi x0 nops in imem and an address pattern in dmem
        for (int i = 0; i < mem_words; i++) begin
            host_write(1'b0, word_bits'(i), i_word(op_imm, 3'b000, 5'd0, 5'd0, 12'(i)), 4'hf);
            host_write(1'b1, word_bits'(i), 32'hc0de_0000 | 32'(i), 4'hf);
        end
        for (int n = 0; n < rand_writes; n++) begin
            rnd = $random(seed);
            host_write(rnd[8], rnd[5:0], $random(seed), rnd[12:9]);
        end
        for (int i = 0; i < mem_words; i++) begin
            host_check(1'b0, word_bits'(i));  // alternating select
            host_check(1'b1, word_bits'(i));
        end

        a = $random(seed);
        b = $random(seed);
        if (a == b)
            b = b ^ 32'h1;                    // beq x1, x2 must fall through
        load_constant(5'd1, a);
        load_constant(5'd2, b);
        prog.push_back(r_word(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));  // add
        prog.push_back(r_word(7'h20, 3'b000, 5'd4, 5'd3, 5'd2));  // sub
        prog.push_back(r_word(7'h00, 3'b111, 5'd5, 5'd4, 5'd3));  // and
        prog.push_back(r_word(7'h00, 3'b110, 5'd6, 5'd5, 5'd1));  // or
        prog.push_back(r_word(7'h00, 3'b100, 5'd7, 5'd6, 5'd2));  // xor
        prog.push_back(r_word(7'h00, 3'b010, 5'd8, 5'd7, 5'd1));  // slt
        for (int r = 3; r <= 8; r++)
            prog.push_back(sw_word(5'(r), 5'd0, 12'(4 * (r - 3))));
        prog.push_back(i_word(op_load, 3'b010, 5'd9, 5'd0, 12'd0));  // lw used by the next add
        prog.push_back(r_word(7'h00, 3'b000, 5'd10, 5'd9, 5'd1));
        prog.push_back(sw_word(5'd10, 5'd0, 12'd24));
        prog.push_back(i_word(op_imm, 3'b000, 5'd11, 5'd0, 12'hfff));  // marker
        prog.push_back(branch_word(3'b000, 5'd1, 5'd1, 13'd12));  // beq taken
        prog.push_back(sw_word(5'd11, 5'd0, 12'd28));
        prog.push_back(sw_word(5'd11, 5'd0, 12'd32));
        prog.push_back(branch_word(3'b001, 5'd1, 5'd1, 13'd8));   // bne not taken
        prog.push_back(sw_word(5'd1, 5'd0, 12'd36));
        prog.push_back(branch_word(3'b000, 5'd1, 5'd2, 13'd8));   // beq not taken
        prog.push_back(sw_word(5'd2, 5'd0, 12'd40));
        prog.push_back(branch_word(3'b001, 5'd1, 5'd2, 13'd12));  // bne taken
        prog.push_back(sw_word(5'd11, 5'd0, 12'd44));
        prog.push_back(sw_word(5'd11, 5'd0, 12'd48));
        jal_pc = 4 * prog.size();
        prog.push_back(jal_word(5'd12, 21'd12));
        prog.push_back(sw_word(5'd11, 5'd0, 12'd52));
        prog.push_back(sw_word(5'd11, 5'd0, 12'd56));
        prog.push_back(sw_word(5'd12, 5'd0, 12'd60));                // link
        prog.push_back(i_word(op_imm, 3'b000, 5'd0, 5'd0, 12'd5));  // write to x0
        prog.push_back(sw_word(5'd0, 5'd0, 12'd64));
        prog.push_back(i_word(op_system, 3'b000, 5'd0, 5'd0, 12'd0));  // ecall
        prog.push_back(sw_word(5'd11, 5'd0, 12'd68));  // past the halt
        foreach (prog[i])
            host_write(1'b0, word_bits'(i), prog[i], 4'hf);

        reset  = 1'b0;
        cycles = 0;
        while (run) begin
            @(negedge clk_in);
            cycles++;
            if (cycles > run_limit)
                stop_with_fail("timeout: run stayed high and the program never halted");
        end

        res[0] = a + b;
        res[1] = res[0] - b;
        res[2] = res[1] & res[0];
        res[3] = res[2] | a;
        res[4] = res[3] ^ b;
        res[5] = ($signed(res[4]) < $signed(a)) ? 32'd1 : 32'd0;
        for (int r = 0; r < 6; r++)
            dmem_model[r] = res[r];
        dmem_model[6]  = res[0] + a;        // load-use sum
        dmem_model[9]  = a;                 // not-taken paths ran
        dmem_model[10] = b;
        dmem_model[15] = 32'(jal_pc + 4);
        dmem_model[16] = '0;
        // words 7, 8, 11 to 14 and 17 keep their old contents
        for (int i = 0; i < mem_words; i++) begin
            host_check(1'b1, word_bits'(i));
            host_check(1'b0, word_bits'(i));
        end

        if (UUT.props.fail_count == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            stop_with_fail("a property check on the top-level ports failed during the run");
        end
    end

endmodule

//--- build.f
hw/rv_pkg.sv
hw/instruction_fetch.sv
hw/instruction_decode.sv
hw/execute.sv
hw/memory_access.sv
hw/pipelined_processor.sv
test/processor_props.sv
test/processor_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= processor_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= TESTS PASSED
VFLAGS    ?= --timing --assert

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
